// ==== xcvr_avmm_params.svh ====
`ifndef XCVR_AVMM_PARAMS_SVH
`define XCVR_AVMM_PARAMS_SVH

// ******************************
// Avalon-MM bus widths
// ******************************
`define XCVR_AVMM_ADDR_W   9       // User and channel address width
`define XCVR_AVMM_DATA_W   8       // One byte per access
`define XCVR_AVMM_RCNT_W   3       // Read cycle counter width

// ******************************
// Read timing
// ******************************
`define XCVR_AVMM_READ_LAT 3'd3    // Hard block read latency in cycles
// Counter value held in reset
// Sits above the latency so the wait decode can tell it apart
`define XCVR_AVMM_RCNT_RST 3'd7

// ******************************
// Arbiter and block map
// ******************************
`define XCVR_AVMM_ARB_ADDR 9'h000  // Calibration arbiter register
`define XCVR_AVMM_NUM_BLK  8       // PMA, PCS and PLL blocks on the return bus

`endif

// ==== xcvr_avmm_pkg.sv ====
`include "xcvr_avmm_params.svh"

package xcvr_avmm_pkg;

    // ******************************
    // Plain vectors
    // ******************************
    typedef logic [`XCVR_AVMM_ADDR_W-1:0] avmm_addr_t;   // Register address
    typedef logic [`XCVR_AVMM_DATA_W-1:0] avmm_data_t;   // Read or write byte
    typedef logic [`XCVR_AVMM_RCNT_W-1:0] read_cnt_t;    // Read cycle count

    // One select bit per hard block
    typedef logic [`XCVR_AVMM_NUM_BLK-1:0] blk_sel_t;

    // Byte k of the bus belongs to block k
    typedef logic [`XCVR_AVMM_NUM_BLK*`XCVR_AVMM_DATA_W-1:0] blk_rdata_t;

    // ******************************
    // Bundles
    // ******************************
    // One Avalon-MM command, user side and block side alike
    typedef struct packed {
        logic       write;
        logic       read;
        avmm_addr_t address;
        avmm_data_t writedata;
    } avmm_cmd_t;

    // Read cycle status toward the response stage
    typedef struct packed {
        logic read_wait;    // Hold the master off
        logic capture;      // Block read data is valid this cycle
    } read_status_t;

    // ******************************
    // Arbiter FSM
    // ******************************
    typedef enum logic [1:0] {
        ARB_USER    = 2'd0,    // User owns the bus
        ARB_CAL     = 2'd1,    // Handed to calibration
        ARB_RELEASE = 2'd2     // Calibration done, busy pipeline draining
    } arb_state_e;

endpackage

// ==== read_wait_gen.sv ====
`include "xcvr_avmm_params.svh"

module read_wait_gen (
    input  logic                        avmm_clk,
    input  logic                        rst,
    input  logic                        user_read,
    input  logic                        cal_owned,
    output xcvr_avmm_pkg::read_status_t read_status
);

    localparam xcvr_avmm_pkg::read_cnt_t read_lat    = `XCVR_AVMM_READ_LAT;
    localparam xcvr_avmm_pkg::read_cnt_t read_last   = read_lat + 1'b1;  // Completion count
    localparam xcvr_avmm_pkg::read_cnt_t cnt_rst_val = `XCVR_AVMM_RCNT_RST;

    logic                      read_r;      // Read already seen and being counted
    logic                      read_new;    // First cycle of a read
    logic                      read_done;   // Count reached completion
    logic                      cnt_active;  // Inside the latency window
    logic                      cnt_in_rst;  // Counter parked at its reset value

    // Power-up value matches reset so the master is held off from the first cycle
    xcvr_avmm_pkg::read_cnt_t  read_cnt = `XCVR_AVMM_RCNT_RST;

    // ******************************
    // Count decode
    // ******************************
    assign cnt_active = (read_cnt != '0) && (read_cnt <= read_lat);
    assign read_done  = (read_cnt == read_last);
    assign cnt_in_rst = (read_cnt == cnt_rst_val);
    assign read_new   = user_read & ~read_r;

    // Registered read
    // Drops on completion so a back-to-back read shows up as new again
    always_ff @(posedge avmm_clk) begin
        if (rst) begin
            read_r <= 1'b0;
        end else begin
            read_r <= user_read & ~cal_owned & ~read_done & ~cnt_in_rst;
        end
    end

    // ******************************
    // Read cycle counter
    // ******************************
    always_ff @(posedge avmm_clk) begin
        if (rst) begin
            read_cnt <= cnt_rst_val;             // Keeps waitrequest up in reset
        end else if (cal_owned) begin
            read_cnt <= read_cnt;                // Frozen while calibration has the bus
        end else if (user_read && (read_cnt == '0)) begin
            read_cnt <= read_cnt + 1'b1;         // Start of a read
        end else if (cnt_active) begin
            read_cnt <= read_cnt + 1'b1;         // Step through the latency
        end else begin
            read_cnt <= '0;                      // Completion or leaving reset
        end
    end

    // Wait on a fresh read, through the latency, and in the reset park state
    assign read_status.read_wait = read_new | cnt_active | cnt_in_rst;

    // Last latency cycle, block data settled on the return bus
    assign read_status.capture   = (read_cnt == read_lat);

    // ******************************
    // Checks
    // ******************************
    // Counter only visits 0 through completion, or the reset value
    a_cnt_range: assert property (@(posedge avmm_clk) disable iff (rst)
        !((read_cnt > read_last) && (read_cnt < cnt_rst_val)))
        else $error("read counter left its legal range: %0d", read_cnt);

endmodule

// ==== cal_arbiter.sv ====
`include "xcvr_avmm_params.svh"

module cal_arbiter (
    input  logic                     avmm_clk,
    input  logic                     rst,
    input  xcvr_avmm_pkg::avmm_cmd_t user_cmd,
    input  logic                     cal_busy,
    output logic                     cal_owned,
    output logic                     write_wait,
    output logic                     cal_request,
    output xcvr_avmm_pkg::avmm_cmd_t chnl_cmd
);

    localparam xcvr_avmm_pkg::avmm_addr_t arb_addr = `XCVR_AVMM_ARB_ADDR;

    logic                        busy_r1;       // cal_busy one cycle late
    logic                        busy_r2;       // cal_busy two cycles late
    logic                        arb_hit;       // Write to the arbiter register
    logic                        handoff_wr;    // Bit 0 set gives the bus away
    logic                        request_wr;    // Bit 0 clear asks for the bus back
    logic                        busy_fell;     // Calibration just let go
    logic                        busy_drained;  // Falling edge has left the pipeline

    xcvr_avmm_pkg::arb_state_e   state;
    xcvr_avmm_pkg::arb_state_e   state_nxt;

    logic                        chnl_write;
    logic                        chnl_read;
    xcvr_avmm_pkg::avmm_addr_t   chnl_addr;
    xcvr_avmm_pkg::avmm_data_t   chnl_wdata;

    // ******************************
    // Busy pipeline
    // ******************************
    // Two-stage history of the engine busy flag
    always_ff @(posedge avmm_clk) begin
        busy_r1 <= cal_busy;
        busy_r2 <= busy_r1;
    end

    assign cal_owned    = busy_r1;
    assign busy_fell    = busy_r1 & ~cal_busy;
    assign busy_drained = busy_r2 & ~busy_r1;

    // Arbiter register decode taken only once the write can complete
    assign arb_hit    = user_cmd.write && (user_cmd.address == arb_addr);
    assign handoff_wr = arb_hit & user_cmd.writedata[0] & ~write_wait;
    assign request_wr = arb_hit & ~user_cmd.writedata[0] & ~write_wait;

    // ******************************
    // Ownership FSM
    // ******************************
    always_comb begin
        state_nxt = state;
        case (state)
            xcvr_avmm_pkg::ARB_USER: begin
                if (handoff_wr) begin
                    state_nxt = xcvr_avmm_pkg::ARB_CAL;
                end
            end
            xcvr_avmm_pkg::ARB_CAL: begin
                if (busy_fell) begin
                    state_nxt = xcvr_avmm_pkg::ARB_RELEASE;    // Engine is done
                end
            end
            xcvr_avmm_pkg::ARB_RELEASE: begin
                if (!busy_r1 && !busy_r2) begin
                    state_nxt = xcvr_avmm_pkg::ARB_USER;       // Both stages quiet
                end
            end
            default: begin
                state_nxt = xcvr_avmm_pkg::ARB_USER;
            end
        endcase
    end

    always_ff @(posedge avmm_clk) begin
        if (rst) begin
            state <= xcvr_avmm_pkg::ARB_USER;
        end else begin
            state <= state_nxt;
        end
    end

    // Held off during a handoff and whenever calibration drives the bus
    assign write_wait = (state != xcvr_avmm_pkg::ARB_USER) | cal_owned;

    // Request to calibration cleared two cycles after busy is seen low
    always_ff @(posedge avmm_clk) begin
        if (rst) begin
            cal_request <= 1'b0;
        end else if (request_wr) begin
            cal_request <= 1'b1;
        end else if (busy_drained) begin
            cal_request <= 1'b0;
        end
    end

    // ******************************
    // Command fan-out
    // ******************************
    // Strobes blocked while the bus is owned and arbiter writes kept local
    always_ff @(posedge avmm_clk) begin
        if (rst) begin
            chnl_write <= 1'b0;
            chnl_read  <= 1'b0;
        end else begin
            chnl_write <= user_cmd.write & ~write_wait & (user_cmd.address != arb_addr);
            chnl_read  <= user_cmd.read & ~write_wait;
        end
    end

    always_ff @(posedge avmm_clk) begin
        chnl_addr  <= user_cmd.address;    // Address follows even when blocked
        chnl_wdata <= user_cmd.writedata;
    end

    assign chnl_cmd.write     = chnl_write;
    assign chnl_cmd.read      = chnl_read;
    assign chnl_cmd.address   = chnl_addr;
    assign chnl_cmd.writedata = chnl_wdata;

    // ******************************
    // Checks
    // ******************************
    a_no_req_in_cal: assert property (@(posedge avmm_clk) disable iff (rst)
        (state == xcvr_avmm_pkg::ARB_CAL) |-> !$rose(cal_request))
        else $error("cal_request rose while calibration owns the bus");

    a_no_arb_fwd: assert property (@(posedge avmm_clk) disable iff (rst)
        !(chnl_cmd.write && (chnl_cmd.address == arb_addr)))
        else $error("arbiter write leaked onto the block bus");

endmodule

// ==== avmm_response.sv ====
`include "xcvr_avmm_params.svh"

module avmm_response (
    input  logic                        avmm_clk,
    input  logic                        rst,
    input  xcvr_avmm_pkg::read_status_t read_status,
    input  logic                        write_wait,
    input  logic                        cal_owned,
    input  xcvr_avmm_pkg::blk_sel_t     blk_sel,
    input  xcvr_avmm_pkg::blk_rdata_t   blk_rdata,
    output logic                        avmm_waitrequest,
    output xcvr_avmm_pkg::avmm_data_t   avmm_readdata
);

    xcvr_avmm_pkg::avmm_data_t  rdata_mux;    // OR of the selected block bytes

    // ******************************
    // Waitrequest
    // ******************************
    // Either source holds the master
    assign avmm_waitrequest = read_status.read_wait | write_wait;

    // ******************************
    // Read data return
    // ******************************
    // AND-OR merge of the return bus
    // Unselected blocks contribute nothing, no select reads back 0
    always_comb begin
        rdata_mux = '0;
        for (int k = 0; k < `XCVR_AVMM_NUM_BLK; k++) begin
            rdata_mux = rdata_mux |
                (blk_rdata[k*`XCVR_AVMM_DATA_W +: `XCVR_AVMM_DATA_W] &
                 {`XCVR_AVMM_DATA_W{blk_sel[k]}});
        end
    end

    // Capture on the last latency cycle
    // Skipped while calibration drives the blocks, its data is not ours
    always_ff @(posedge avmm_clk) begin
        if (rst) begin
            avmm_readdata <= '0;
        end else if (read_status.capture && !cal_owned) begin
            avmm_readdata <= rdata_mux;    // Valid when waitrequest drops
        end
    end

    // ******************************
    // Checks
    // ******************************
    // Depends on the read counter parking at its reset value
    a_wait_in_rst: assert property (@(posedge avmm_clk)
        rst |-> avmm_waitrequest)
        else $error("waitrequest low during reset");

endmodule

// ==== xcvr_avmm.sv ====
module xcvr_avmm (
    input  logic                       avmm_clk,
    input  logic                       rst,
    // User Avalon-MM slave
    input  xcvr_avmm_pkg::avmm_cmd_t   user_cmd,
    output xcvr_avmm_pkg::avmm_data_t  avmm_readdata,
    output logic                       avmm_waitrequest,
    // Calibration engine
    input  logic                       cal_busy,
    output logic                       cal_request,
    // Hard block side
    output xcvr_avmm_pkg::avmm_cmd_t   chnl_cmd,
    input  xcvr_avmm_pkg::blk_sel_t    blk_sel,
    input  xcvr_avmm_pkg::blk_rdata_t  blk_rdata
);

    logic                         cal_owned;    // Calibration holds the bus
    logic                         write_wait;   // Arbiter hold-off
    xcvr_avmm_pkg::read_status_t  read_status;  // Read wait and capture

    // ******************************
    // Read latency
    // ******************************
    read_wait_gen u_read_wait_gen (
        .avmm_clk    (avmm_clk),
        .rst         (rst),
        .user_read   (user_cmd.read),
        .cal_owned   (cal_owned),
        .read_status (read_status)
    );

    // ******************************
    // Calibration ownership
    // ******************************
    cal_arbiter u_cal_arbiter (
        .avmm_clk    (avmm_clk),
        .rst         (rst),
        .user_cmd    (user_cmd),
        .cal_busy    (cal_busy),
        .cal_owned   (cal_owned),
        .write_wait  (write_wait),
        .cal_request (cal_request),
        .chnl_cmd    (chnl_cmd)
    );

    // ******************************
    // Master response
    // ******************************
    avmm_response u_avmm_response (
        .avmm_clk         (avmm_clk),
        .rst              (rst),
        .read_status      (read_status),
        .write_wait       (write_wait),
        .cal_owned        (cal_owned),
        .blk_sel          (blk_sel),
        .blk_rdata        (blk_rdata),
        .avmm_waitrequest (avmm_waitrequest),
        .avmm_readdata    (avmm_readdata)
    );

endmodule

// ==== tb_block_model.sv ====
`include "xcvr_avmm_params.svh"

module tb_block_model (
    input  xcvr_avmm_pkg::avmm_cmd_t  chnl_cmd,
    output xcvr_avmm_pkg::blk_sel_t   blk_sel,
    output xcvr_avmm_pkg::blk_rdata_t blk_rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int dw = `XCVR_AVMM_DATA_W;

    logic [2:0] blk_idx;    // Block number from address bits 5:3

    assign blk_idx = chnl_cmd.address[5:3];

    // ******************************
    // Hard block read return
    // ******************************
    always_comb begin
        blk_sel   = '0;
        blk_rdata = '0;
        // Unselected lanes carry noise that the merge has to mask
        for (int k = 0; k < `XCVR_AVMM_NUM_BLK; k++) begin
            blk_rdata[k*dw +: dw] = ~chnl_cmd.address[7:0] ^ {chnl_cmd.address[8], 7'(k)};
        end
        if (!chnl_cmd.address[8]) begin    // Bit 8 set addresses no block
            blk_sel[blk_idx]           = 1'b1;
            blk_rdata[blk_idx*dw +: dw] = chnl_cmd.address[7:0] ^ (8'(blk_idx) * 8'h11);
        end
    end

endmodule

// ==== tb_xcvr_avmm.sv ====
`include "xcvr_avmm_params.svh"

module tb_xcvr_avmm;

    timeunit 1ns;
    timeprecision 100ps;

    // ******************************
    // Stimulus table types
    // ******************************
    typedef enum logic [2:0] {
        OP_READ,         // Plain read with fixed latency
        OP_WRITE,        // Plain write to a block
        OP_HANDOFF,      // Arbiter write with bit 0 set
        OP_REQUEST,      // Arbiter write with bit 0 clear
        OP_BUSY_READ     // Read issued while calibration is busy
    } op_kind_e;

    typedef struct packed {
        op_kind_e                  kind;
        xcvr_avmm_pkg::avmm_addr_t addr;
        xcvr_avmm_pkg::avmm_data_t data;
        logic [7:0]                busy_len;   // Cycles of cal_busy
        xcvr_avmm_pkg::avmm_data_t exp_val;    // Read byte or a cycle count
    } stim_t;

    localparam int num_entries = 14;
    localparam int read_waits  = `XCVR_AVMM_READ_LAT + 1;    // T0 through T3
    localparam int cycle_limit = 40 * num_entries + 50;
    localparam xcvr_avmm_pkg::avmm_addr_t arb_addr = `XCVR_AVMM_ARB_ADDR;

    logic                      avmm_clk = 1'b0;
    logic                      rst;
    xcvr_avmm_pkg::avmm_cmd_t  user_cmd;
    xcvr_avmm_pkg::avmm_data_t avmm_readdata;
    logic                      avmm_waitrequest;
    logic                      cal_busy;
    logic                      cal_request;
    xcvr_avmm_pkg::avmm_cmd_t  chnl_cmd;
    xcvr_avmm_pkg::blk_sel_t   blk_sel;
    xcvr_avmm_pkg::blk_rdata_t blk_rdata;

    stim_t       tbl [num_entries];
    logic [31:0] lcg_state = 32'h9b5;
    int          err_cnt   = 0;
    int          done_cnt  = 0;    // Table entries finished
    int          cycle_cnt = 0;

    always #10 avmm_clk = ~avmm_clk;    // 20 ns period

    xcvr_avmm dut (
        .avmm_clk         (avmm_clk),
        .rst              (rst),
        .user_cmd         (user_cmd),
        .avmm_readdata    (avmm_readdata),
        .avmm_waitrequest (avmm_waitrequest),
        .cal_busy         (cal_busy),
        .cal_request      (cal_request),
        .chnl_cmd         (chnl_cmd),
        .blk_sel          (blk_sel),
        .blk_rdata        (blk_rdata)
    );

    tb_block_model u_block_model (
        .chnl_cmd  (chnl_cmd),
        .blk_sel   (blk_sel),
        .blk_rdata (blk_rdata)
    );

    // Run limit
    always @(posedge avmm_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycle_limit);
            $display("Entries run %0d of %0d, errors %0d", done_cnt, num_entries, err_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ******************************
    // Helpers
    // ******************************
    function automatic xcvr_avmm_pkg::avmm_data_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];    // Upper bits spread better
    endfunction

    function automatic void load_table();
        // Read bytes follow the block rule of low address byte XOR k*0x11
        tbl[0]  = '{OP_READ,      9'h005, 8'h00,                 8'd0, 8'h05};
        tbl[1]  = '{OP_READ,      9'h03c, 8'h00,                 8'd0, 8'h4b};
        tbl[2]  = '{OP_WRITE,     9'h013, rand_byte(),           8'd0, 8'h00};
        tbl[3]  = '{OP_READ,      9'h1a6, 8'h00,                 8'd0, 8'h00};  // No block
        tbl[4]  = '{OP_READ,      9'h0d1, 8'h00,                 8'd0, 8'hf3};
        tbl[5]  = '{OP_HANDOFF,   arb_addr, rand_byte() | 8'h01, 8'd5, 8'd2};
        tbl[6]  = '{OP_READ,      9'h098, 8'h00,                 8'd0, 8'hab};
        tbl[7]  = '{OP_REQUEST,   arb_addr, rand_byte() & 8'hfe, 8'd4, 8'd2};
        tbl[8]  = '{OP_WRITE,     9'h1ff, rand_byte(),           8'd0, 8'h00};
        tbl[9]  = '{OP_BUSY_READ, 9'h06e, 8'h00,                 8'd6, 8'h3b};
        tbl[10] = '{OP_READ,      9'h0ef, 8'h00,                 8'd0, 8'hba};
        tbl[11] = '{OP_WRITE,     9'h120, rand_byte(),           8'd0, 8'h00};
        tbl[12] = '{OP_BUSY_READ, 9'h04a, 8'h00,                 8'd3, 8'h5b};
        tbl[13] = '{OP_READ,      9'h029, 8'h00,                 8'd0, 8'h7c};
    endfunction

    task automatic drive_cmd(input logic wr, input logic rd,
                             input xcvr_avmm_pkg::avmm_addr_t addr,
                             input xcvr_avmm_pkg::avmm_data_t data);
        @(posedge avmm_clk);
        #2;
        user_cmd = '{wr, rd, addr, data};
    endtask

    task automatic go_idle();
        @(posedge avmm_clk);
        #2;
        user_cmd = '0;
    endtask

    // Counts mid-cycle samples with waitrequest high and returns in the completing cycle
    task automatic wait_ready(output int waits);
        waits = 0;
        @(negedge avmm_clk);
        while (avmm_waitrequest) begin
            waits++;
            @(negedge avmm_clk);
        end
    endtask

    // ******************************
    // Reset and transactions
    // ******************************
    task automatic check_reset();
        repeat (3) begin
            @(posedge avmm_clk);
            #2;
            if (!avmm_waitrequest) begin
                err_cnt++;
                $display("FAIL avmm_waitrequest in reset: got 0x0 expected 0x1");
            end
        end
        rst = 1'b0;
        @(negedge avmm_clk);    // First cycle out of reset with the counter still parked
        if (!avmm_waitrequest) begin
            err_cnt++;
            $display("FAIL avmm_waitrequest after reset: got 0x0 expected 0x1");
        end
        if (cal_request || chnl_cmd.read || chnl_cmd.write) begin
            err_cnt++;
            $display("FAIL cal_request/chnl_cmd after reset: got 0x%h/0x%h/0x%h expected 0x0",
                     cal_request, chnl_cmd.read, chnl_cmd.write);
        end
    endtask

    task automatic plain_read(input stim_t s);
        int waits;
        drive_cmd(1'b0, 1'b1, s.addr, 8'h00);
        wait_ready(waits);
        if (waits != read_waits) begin
            err_cnt++;
            $display("FAIL avmm_waitrequest read 0x%h: high 0x%h cycles expected 0x%h",
                     s.addr, waits, read_waits);
        end
        if (avmm_readdata !== s.exp_val) begin
            err_cnt++;
            $display("FAIL avmm_readdata read 0x%h: got 0x%h expected 0x%h",
                     s.addr, avmm_readdata, s.exp_val);
        end
        // Fanned-out read still on the block side
        if (chnl_cmd.read !== 1'b1 || chnl_cmd.address !== s.addr) begin
            err_cnt++;
            $display("FAIL chnl_cmd read: got 0x%h @0x%h expected 0x1 @0x%h",
                     chnl_cmd.read, chnl_cmd.address, s.addr);
        end
        go_idle();
    endtask

    task automatic plain_write(input stim_t s);
        int waits;
        drive_cmd(1'b1, 1'b0, s.addr, s.data);
        wait_ready(waits);
        if (waits != 0) begin
            err_cnt++;
            $display("FAIL avmm_waitrequest write 0x%h: high 0x%h cycles expected 0x0",
                     s.addr, waits);
        end
        if (chnl_cmd.write) begin
            err_cnt++;
            $display("Write to 0x%h reached the blocks in its own cycle", s.addr);
        end
        go_idle();
        @(negedge avmm_clk);    // One cycle later on the block side
        if (!chnl_cmd.write || chnl_cmd.address !== s.addr || chnl_cmd.writedata !== s.data) begin
            err_cnt++;
            $display("FAIL chnl_cmd write: got 0x%h @0x%h = 0x%h expected 0x1 @0x%h = 0x%h",
                     chnl_cmd.write, chnl_cmd.address, chnl_cmd.writedata, s.addr, s.data);
        end
    endtask

    // Arbiter write followed by calibration busy for busy_len cycles
    task automatic arbiter_write(input stim_t s);
        int waits;
        drive_cmd(1'b1, 1'b0, s.addr, s.data);
        wait_ready(waits);
        if (waits != 0) begin
            err_cnt++;
            $display("FAIL avmm_waitrequest arbiter write: high 0x%h cycles expected 0x0", waits);
        end
        go_idle();
        cal_busy = 1'b1;
        for (int i = 0; i < s.busy_len; i++) begin
            @(negedge avmm_clk);
            if (s.kind == OP_HANDOFF && !avmm_waitrequest) begin
                err_cnt++;
                $display("Waitrequest dropped while calibration owned the bus");
            end
            if (s.kind == OP_REQUEST && !cal_request) begin
                err_cnt++;
                $display("FAIL cal_request busy cycle %0d: got 0x0 expected 0x1", i);
            end
            if (chnl_cmd.write) begin
                err_cnt++;
                $display("Arbiter write was forwarded to the blocks");
            end
        end
        @(posedge avmm_clk);
        #2;
        cal_busy = 1'b0;
        waits = 0;
        @(negedge avmm_clk);
        // Handoff holds waitrequest and a request holds cal_request
        while ((s.kind == OP_HANDOFF) ? avmm_waitrequest : cal_request) begin
            waits++;
            @(negedge avmm_clk);
        end
        if (s.kind == OP_HANDOFF && waits < s.exp_val) begin
            err_cnt++;
            $display("FAIL avmm_waitrequest release: high 0x%h cycles after busy, expected >= 0x%h",
                     waits, s.exp_val);
        end
        if (s.kind == OP_REQUEST && waits != s.exp_val) begin
            err_cnt++;
            $display("FAIL cal_request release: high 0x%h cycles after busy, expected 0x%h",
                     waits, s.exp_val);
        end
    endtask

    task automatic read_under_busy(input stim_t s);
        int waits;
        @(posedge avmm_clk);
        #2;
        cal_busy = 1'b1;    // Ownership seen one cycle later
        drive_cmd(1'b0, 1'b1, s.addr, 8'h00);
        for (int i = 0; i < s.busy_len; i++) begin
            @(negedge avmm_clk);
            if (!avmm_waitrequest) begin
                err_cnt++;
                $display("Read 0x%h completed while calibration was busy", s.addr);
            end
        end
        @(posedge avmm_clk);
        #2;
        cal_busy = 1'b0;
        wait_ready(waits);
        if (waits < read_waits) begin
            err_cnt++;
            $display("FAIL avmm_waitrequest busy read: high 0x%h cycles after busy, expected >= 0x%h",
                     waits, read_waits);
        end
        if (avmm_readdata !== s.exp_val) begin
            err_cnt++;
            $display("FAIL avmm_readdata busy read 0x%h: got 0x%h expected 0x%h",
                     s.addr, avmm_readdata, s.exp_val);
        end
        go_idle();
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        rst      = 1'b1;
        cal_busy = 1'b0;
        user_cmd = '0;
        load_table();
        check_reset();
        for (int i = 0; i < num_entries; i++) begin
            case (tbl[i].kind)
                OP_READ:      plain_read(tbl[i]);
                OP_WRITE:     plain_write(tbl[i]);
                OP_BUSY_READ: read_under_busy(tbl[i]);
                default:      arbiter_write(tbl[i]);    // Handoff and request
            endcase
            done_cnt++;
        end
        repeat (2) @(posedge avmm_clk);
        $display("Entries run %0d of %0d, errors %0d", done_cnt, num_entries, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== xcvr_avmm.f ====
+incdir+.
xcvr_avmm_pkg.sv
read_wait_gen.sv
cal_arbiter.sv
avmm_response.sv
xcvr_avmm.sv
tb_block_model.sv
tb_xcvr_avmm.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP       = tb_xcvr_avmm
FILELIST  = xcvr_avmm.f

.PHONY: sim clean

# Build and run, the status follows the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
